// ==== mcpu.f ====
+incdir+rtl
rtl/mcpu_pkg.sv
rtl/mcpu_bus_if.sv
rtl/cycle_ctrl.sv
rtl/alarm_timer.sv
rtl/bus_port.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/mcpu.sv
sim/mcpu_tb.sv

// ==== rtl/alarm_timer.sv ====
/*
	Bus watchdog. Counts cycles of a pending request and raises alarm
	when MCPU_ALARM_DLY_TICKS pass without done. Alarm holds until reset.
*/
`timescale 1ns/1ps
`include "mcpu_defines.svh"

module alarm_timer (
	input  logic      __clk,
	input  logic      rst_n,
	mcpu_bus_if.watch mem
);

	localparam int unsigned DLY = `MCPU_ALARM_DLY_TICKS;
	localparam int CNT_W = $clog2(DLY + 1);

	logic [CNT_W-1:0] cnt;
	logic waiting;

	assign waiting = mem.req && !mem.done;

	// ---------------------------------------------------------------------
	// wait counter, saturates at the delay

	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			cnt <= '0;
			mem.alarm <= 1'b0;
		end else begin
			if (!waiting) begin
				cnt <= '0;
			end else if (cnt != CNT_W'(DLY)) begin
				cnt <= cnt + 1'b1;
			end
			if (waiting && cnt == CNT_W'(DLY - 1)) begin
				mem.alarm <= 1'b1;	// sticky
			end
		end
	end

	// alarm only after a request open for the whole delay
	a_alarm_on_req: assert property (@(posedge __clk) disable iff (!rst_n)
		$rose(mem.alarm) |-> $past(mem.req, DLY));

endmodule

// ==== rtl/alu.sv ====
/*
	Combinational arithmetic unit for the write state.
	Sums and differences wrap at the word width, no carry is kept.
	Opcodes without a register result pass the accumulator through.
*/
`timescale 1ns/1ps

module alu import mcpu_pkg::*; (
	input  opcode_t alu_op,
	input  word_t   acc,	// selected register
	input  word_t   operand,	// memory word of the exec cycle
	input  word_t   imm,	// zero extended ir[8:0]
	output word_t   result
);

	// ---------------------------------------------------------------------
	// result select

	always_comb begin
		case (alu_op)
			op_aw: begin
				result = acc + operand;
			end
			op_ac: begin
				result = acc - operand;
			end
			op_nr: begin
				result = acc & operand;
			end
			op_lw: begin
				result = operand;	// load through
			end
			op_lwt: begin
				result = imm;
			end
			default: begin
				result = acc;
			end
		endcase
	end

endmodule

// ==== rtl/bus_port.sv ====
/*
	System bus port with a held request and a one-cycle bus_ok answer.
	bus_req drops on the cycle after bus_ok. done and rdata follow
	one cycle after bus_ok is sampled. There is no other back-pressure.
*/
`timescale 1ns/1ps

module bus_port import mcpu_pkg::*; (
	input  logic     __clk,
	input  logic     rst_n,
	mcpu_bus_if.port mem,
	output logic     bus_req,
	output logic     bus_we,
	output addr_t    bus_addr,
	output word_t    bus_wdata,
	input  logic     bus_ok,
	input  word_t    bus_rdata
);

	logic answered;

	assign answered = bus_req && bus_ok;

	// ---------------------------------------------------------------------
	// handshake

	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			bus_req <= 1'b0;
			mem.done <= 1'b0;
		end else begin
			bus_req <= mem.req && !answered;	// no re-raise on the ok cycle
			mem.done <= answered;
		end
	end

	// outgoing cycle, follows the sequencer while it asks
	always_ff @(posedge __clk) begin
		if (mem.req) begin
			bus_addr <= mem.addr;
			bus_we <= mem.we;
			bus_wdata <= mem.wdata;
		end
	end

	always_ff @(posedge __clk) begin
		if (answered) mem.rdata <= bus_rdata;	// held until the next answer
	end

	a_addr_stable: assert property (@(posedge __clk) disable iff (!rst_n)
		bus_req && !bus_ok |=> $stable(bus_addr) && $stable(bus_we));

endmodule

// ==== rtl/cycle_ctrl.sv ====
/*
	Instruction sequencer, one instruction in flight at a time.
	Bus requests follow the next state, so bus_port registers a request
	in the cycle its state is entered. After a halt, an illegal code or
	a bus alarm the sequencer stays in st_stop until reset.
*/
`timescale 1ns/1ps
`include "mcpu_defines.svh"

module cycle_ctrl import mcpu_pkg::*; (
	input  logic     __clk,
	input  logic     rst_n,
	input  logic     start,	// panel start strobe
	input  word_t    kl,	// panel keys, start address
	mcpu_bus_if.seq  mem,
	output opcode_t  alu_op,
	output reg_idx_t rsel,
	input  word_t    rd_val,
	input  logic     zero,
	output logic     wr_en,
	output word_t    imm,
	output logic     run,
	output word_t    w	// panel word
);

	cyc_state_t state, state_d;
	word_t   ir;
	addr_t   ic, ic_d;
	addr_t   ir_addr;
	addr_t   cur_addr;	// address of the cycle in progress
	opcode_t op;
	logic    mem_op, reg_wr, jump_taken, halt_op;

	assign op = opcode_t'(ir[15:12]);
	assign ir_addr = ir[`MCPU_ADDR_W-1:0];
	assign cur_addr = (state == st_fetch) ? ic : ir_addr;

	// ---------------------------------------------------------------------
	// decode

	always_comb begin
		mem_op = 1'b0;
		reg_wr = 1'b0;
		jump_taken = 1'b0;
		halt_op = 1'b0;
		case (op)
			op_lw, op_aw, op_ac, op_nr: begin
				mem_op = 1'b1;
				reg_wr = 1'b1;
			end
			op_rw: mem_op = 1'b1;
			op_lwt: reg_wr = 1'b1;
			op_uj: jump_taken = 1'b1;
			op_jz: jump_taken = zero;
			default: halt_op = 1'b1;	// op_hlt and the undefined codes
		endcase
	end

	// ---------------------------------------------------------------------
	// next state

	always_comb begin
		state_d = state;
		ic_d = ic;
		case (state)
			st_idle: if (start) begin
				state_d = st_fetch;
				ic_d = kl[`MCPU_ADDR_W-1:0];
			end
			st_fetch: if (mem.done) state_d = st_decode;
			st_decode: begin
				ic_d = ic + 1'b1;
				state_d = mem_op ? st_exec_mem : st_write;
			end
			st_exec_mem: if (mem.done) state_d = st_write;
			st_write: begin
				if (halt_op) begin
					state_d = st_stop;
				end else begin
					state_d = st_fetch;
					if (jump_taken) ic_d = ir_addr;
				end
			end
			default: state_d = st_stop;
		endcase
		if (mem.alarm) state_d = st_stop;	// memory never answered
	end

	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			state <= st_idle;
			ic <= '0;
			w <= '0;
		end else begin
			state <= state_d;
			ic <= ic_d;
			if (state != st_stop) w <= mem.alarm ? word_t'(cur_addr) : word_t'(ic_d);
		end
	end

	always_ff @(posedge __clk) begin
		if (state == st_fetch && mem.done) ir <= mem.rdata;
	end

	// memory cycle request
	assign mem.req = (state_d == st_fetch) || (state_d == st_exec_mem);
	assign mem.addr = (state_d == st_fetch) ? ic_d : ir_addr;
	assign mem.we = (state_d == st_exec_mem) && (op == op_rw);
	assign mem.wdata = rd_val;	// store source is the selected register

	assign alu_op = op;
	assign rsel = ir[11:9];
	assign imm = word_t'(ir_addr);	// zero extended
	assign wr_en = (state == st_write) && reg_wr;
	assign run = (state != st_idle) && (state != st_stop);

	a_stop_held: assert property (@(posedge __clk) disable iff (!rst_n)
		state == st_stop |=> state == st_stop);

endmodule

// ==== rtl/mcpu.sv ====
/*
	mcpu top level, a 16-bit sequential processor.
	All ports are active high except rst_n. No interrupts, I/O or paging.
	A start strobe loads the instruction counter from kl.
*/
`timescale 1ns/1ps

module mcpu import mcpu_pkg::*; (
	input  logic  __clk,
	input  logic  rst_n,

	// control panel
	input  logic  start,
	input  word_t kl,
	output word_t w,
	output logic  run,
	output logic  alarm,

	// system bus
	output logic  bus_req,
	output logic  bus_we,
	output addr_t bus_addr,
	output word_t bus_wdata,
	input  logic  bus_ok,
	input  word_t bus_rdata
);

	mcpu_bus_if mem_bus ();

	opcode_t  alu_op;
	reg_idx_t rsel;
	word_t    rd_val;
	word_t    imm;
	word_t    alu_result;
	logic     zero;
	logic     wr_en;

	// ---------------------------------------------------------------------
	// sequencing and bus

	cycle_ctrl seq (
		.__clk(__clk),
		.rst_n(rst_n),
		.start(start),
		.kl(kl),
		.mem(mem_bus.seq),
		.alu_op(alu_op),
		.rsel(rsel),
		.rd_val(rd_val),
		.zero(zero),
		.wr_en(wr_en),
		.imm(imm),
		.run(run),
		.w(w)
	);

	alarm_timer watch (.__clk(__clk), .rst_n(rst_n), .mem(mem_bus.watch));

	bus_port port (
		.__clk(__clk),
		.rst_n(rst_n),
		.mem(mem_bus.port),
		.bus_req(bus_req),
		.bus_we(bus_we),
		.bus_addr(bus_addr),
		.bus_wdata(bus_wdata),
		.bus_ok(bus_ok),
		.bus_rdata(bus_rdata)
	);

	assign alarm = mem_bus.alarm;

	// ---------------------------------------------------------------------
	// data path

	reg_file regs (
		.__clk(__clk),
		.rst_n(rst_n),
		.rsel(rsel),
		.wr_en(wr_en),
		.wr_data(alu_result),
		.rd_val(rd_val),
		.zero(zero)
	);

	alu arith (
		.alu_op(alu_op),
		.acc(rd_val),
		.operand(mem_bus.rdata),	// held since the exec cycle
		.imm(imm),
		.result(alu_result)
	);

endmodule

// ==== rtl/mcpu_bus_if.sv ====
/*
	Memory cycle signals between the sequencer, bus port and alarm timer.
	req is a level held until done, done is a one-cycle pulse.
*/
`timescale 1ns/1ps

interface mcpu_bus_if import mcpu_pkg::*; ();

	logic  req;	// cycle wanted
	logic  we;	// write cycle
	addr_t addr;
	word_t wdata;
	word_t rdata;	// last read word, held
	logic  done;	// memory answered
	logic  alarm;	// sticky, no answer in time

	modport seq (output req, we, addr, wdata, input rdata, done, alarm);

	modport port (input req, we, addr, wdata, output rdata, done);

	modport watch (input req, done, output alarm);

endinterface

// ==== rtl/mcpu_defines.svh ====
/*
	Tunable sizes for mcpu, read the same way by every block.
	The address width must fit the 9-bit low field of the instruction.
	The alarm delay counts __clk cycles of an unanswered request.
*/
`ifndef MCPU_DEFINES_SVH
`define MCPU_DEFINES_SVH

// ---------------------------------------------------------------------
// data path

`define MCPU_WORD_W 16	// one data word
`define MCPU_ADDR_W 9	// taken whole from ir[8:0]
`define MCPU_NREG 8	// general registers r0..r7

// bus watchdog
`define MCPU_ALARM_DLY_TICKS 64	// cycles without bus_ok

`endif

// ==== rtl/mcpu_pkg.sv ====
/*
	Types shared by the mcpu blocks.
	Codes 4'h9 to 4'hf are not defined and stop the processor like op_hlt.
*/
`include "mcpu_defines.svh"

package mcpu_pkg;

	typedef logic [`MCPU_WORD_W-1:0] word_t;
	typedef logic [`MCPU_ADDR_W-1:0] addr_t;
	typedef logic [$clog2(`MCPU_NREG)-1:0] reg_idx_t;

	// instruction word is op[15:12] reg[11:9] addr/imm[8:0]
	typedef enum logic [3:0] {
		op_hlt = 4'h0,
		op_lw  = 4'h1,	// reg = mem
		op_lwt = 4'h2,	// reg = imm
		op_rw  = 4'h3,	// mem = reg
		op_aw  = 4'h4,	// reg += mem
		op_ac  = 4'h5,	// reg -= mem
		op_nr  = 4'h6,	// reg &= mem
		op_uj  = 4'h7,
		op_jz  = 4'h8
	} opcode_t;

	typedef enum logic [2:0] {
		st_idle, st_fetch, st_decode, st_exec_mem, st_write, st_stop
	} cyc_state_t;

endpackage

// ==== rtl/reg_file.sv ====
/*
	Eight general registers and the zero flag.
	One read port selected by rsel, written in the sequencer's write state.
	The zero flag follows every register write.
*/
`timescale 1ns/1ps
`include "mcpu_defines.svh"

module reg_file import mcpu_pkg::*; (
	input  logic     __clk,
	input  logic     rst_n,
	input  reg_idx_t rsel,
	input  logic     wr_en,
	input  word_t    wr_data,
	output word_t    rd_val,
	output logic     zero
);

	word_t regs [`MCPU_NREG];

	// ---------------------------------------------------------------------
	// registers, all start at zero

	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `MCPU_NREG; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[rsel] <= wr_data;
		end
	end

	// zero flag
	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			zero <= 1'b0;
		end else if (wr_en) begin
			zero <= (wr_data == '0);
		end
	end

	assign rd_val = regs[rsel];

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds the mcpu testbench with Verilator and runs it, log goes to sim.log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module mcpu_tb -f mcpu.f -o mcpu_sim

status=0
./obj_dir/mcpu_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Test failures found" sim.log || [ "$status" -ne 0 ]; then
	echo "simulation failed, see sim.log"
	exit 1
fi
echo "simulation passed"

// ==== sim/mcpu_tb.sv ====
/*
	Testbench for mcpu with a 512-word memory model and a reference interpreter.
	Memory answers 0 to 5 cycles after a request, one address can be left
	unanswered for the alarm test. Every program starts from a fresh reset.
*/
`timescale 1ns/1ps
`include "mcpu_defines.svh"

module mcpu_tb import mcpu_pkg::*; ();

	logic  __clk;
	logic  rst_n;
	logic  start;
	word_t kl;
	word_t w;
	logic  run;
	logic  alarm;
	logic  bus_req;
	logic  bus_we;
	addr_t bus_addr;
	word_t bus_wdata;
	logic  bus_ok = 1'b0;
	word_t bus_rdata = '0;

	word_t image [512];	// program as loaded
	word_t mem [512];	// live memory behind the bus
	addr_t exp_addr [$];
	word_t exp_data [$];
	addr_t obs_addr [$];	// stores seen on the bus
	word_t obs_data [$];
	logic  pending = 1'b0;
	int unsigned delay = 0;
	logic  ignore_on;
	addr_t ignore_addr;

	mcpu dut_i (
		.__clk(__clk),
		.rst_n(rst_n),
		.start(start),
		.kl(kl),
		.w(w),
		.run(run),
		.alarm(alarm),
		.bus_req(bus_req),
		.bus_we(bus_we),
		.bus_addr(bus_addr),
		.bus_wdata(bus_wdata),
		.bus_ok(bus_ok),
		.bus_rdata(bus_rdata)
	);

	initial begin
		__clk = 1'b0;
		forever #4 __clk = ~__clk;
	end

	// ---------------------------------------------------------------------
	// failure reporting and compare tasks

	task automatic stop_on_failure();
		$display("Test failures found");
		$fatal(1, "first error ends the run");
	endtask

	task automatic check_addr(input addr_t got, input addr_t exp, input string what);
		if (got !== exp) begin
			$display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_word(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			$display("mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_run(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic report_timeout(input string what);
		cyc_state_t st;
		st = dut_i.seq.state;
		$display("timeout waiting for %s, sequencer in %s", what, st.name());
		stop_on_failure();
	endtask

	// ---------------------------------------------------------------------
	// memory model, answers on the falling edge

	always @(negedge __clk) begin
		if (!rst_n) begin
			bus_ok = 1'b0;
			pending = 1'b0;
		end else if (bus_ok) begin
			bus_ok = 1'b0;	// one-cycle answer
		end else if (bus_req) begin
			if (!pending) begin
				pending = 1'b1;
				delay = $urandom_range(5, 0);
			end
			if (ignore_on && bus_addr == ignore_addr) begin
				pending = 1'b1;	// never answered
			end else if (delay == 0) begin
				pending = 1'b0;
				bus_ok = 1'b1;
				if (bus_we) begin
					mem[bus_addr] = bus_wdata;
					obs_addr.push_back(bus_addr);
					obs_data.push_back(bus_wdata);
				end else begin
					bus_rdata = mem[bus_addr];
				end
			end else begin
				delay--;
			end
		end
	end

	// store checker
	always @(negedge __clk) begin
		if (obs_addr.size() != 0) begin
			if (exp_addr.size() == 0) begin
				$display("store of %h to %h was not expected", obs_data[0], obs_addr[0]);
				stop_on_failure();
			end else begin
				check_addr(obs_addr.pop_front(), exp_addr.pop_front(), "store address");
				check_word(obs_data.pop_front(), exp_data.pop_front(), "store data");
			end
		end
	end

	// ---------------------------------------------------------------------
	// programs and the reference interpreter

	function automatic word_t encode(input opcode_t op, input reg_idx_t r, input addr_t a);
		return {op, r, a};
	endfunction

	function automatic void fill_memory();
		int i;
		for (i = 0; i < 512; i++) begin
			image[i] = word_t'(i * 40503) ^ word_t'(i << 7);
		end
	endfunction

	// runs the program on a copy of the image, returns halt address plus one
	function automatic word_t predict(input addr_t start_addr, output addr_t st_a[$],
			output word_t st_d[$]);
		word_t    m [512];
		word_t    r [`MCPU_NREG];
		logic     z;
		addr_t    pc;
		addr_t    a;
		reg_idx_t ri;
		word_t    ins;
		int       i;
		st_a.delete();
		st_d.delete();
		for (i = 0; i < 512; i++) begin
			m[i] = image[i];
		end
		for (i = 0; i < `MCPU_NREG; i++) begin
			r[i] = '0;
		end
		z = 1'b0;
		pc = start_addr;
		for (i = 0; i < 4096; i++) begin
			ins = m[pc];
			ri = ins[11:9];
			a = ins[8:0];
			pc = pc + 9'd1;
			case (ins[15:12])
				op_lw: r[ri] = m[a];
				op_lwt: r[ri] = word_t'(a);
				op_rw: begin
					m[a] = r[ri];
					st_a.push_back(a);
					st_d.push_back(r[ri]);
				end
				op_aw: r[ri] = r[ri] + m[a];
				op_ac: r[ri] = r[ri] - m[a];
				op_nr: r[ri] = r[ri] & m[a];
				op_uj: pc = a;
				op_jz: if (z) pc = a;
				default: return word_t'(pc);	// halt or undefined code
			endcase
			if (ins[15:12] inside {op_lw, op_lwt, op_aw, op_ac, op_nr}) z = (r[ri] == '0);
		end
		return '0;	// runaway program
	endfunction

	// ---------------------------------------------------------------------
	// sequencing

	task automatic apply_reset();
		@(negedge __clk);
		rst_n = 1'b0;
		start = 1'b0;
		repeat (2) @(negedge __clk);
		rst_n = 1'b1;
	endtask

	task automatic hold_until_stopped(input int limit);
		int k;
		k = 0;
		while (run && k < limit) begin
			@(negedge __clk);
			k++;
		end
		if (run) report_timeout("run to fall");
	endtask

	task automatic catch_first_request(input int limit);
		int k;
		k = 0;
		while (!bus_req && k < limit) begin
			@(negedge __clk);
			k++;
		end
		if (!bus_req) report_timeout("the first bus request");
	endtask

	task automatic expect_alarm(input int limit);
		int k;
		k = 0;
		while (!alarm && k < limit) begin
			@(negedge __clk);
			k++;
		end
		if (!alarm) report_timeout("the bus alarm");
	endtask

	// reset, idle checks, start strobe and first fetch address
	task automatic launch(input addr_t start_addr);
		int i;
		for (i = 0; i < 512; i++) begin
			mem[i] = image[i];
		end
		apply_reset();
		check_run(run, 1'b0, "run after reset");
		check_run(bus_req, 1'b0, "bus_req after reset");
		check_run(alarm, 1'b0, "alarm after reset");
		kl = word_t'(start_addr);
		start = 1'b1;
		@(negedge __clk);
		start = 1'b0;
		catch_first_request(20);
		check_addr(bus_addr, start_addr, "first fetch address");
	endtask

	task automatic run_program(input addr_t start_addr, input string name);
		word_t exp_w;
		addr_t pa [$];
		word_t pd [$];
		exp_w = predict(start_addr, pa, pd);
		exp_addr = pa;
		exp_data = pd;
		launch(start_addr);
		hold_until_stopped(4000);
		check_run(bus_req, 1'b0, {name, " bus_req at halt"});
		check_run(alarm, 1'b0, {name, " alarm at halt"});
		check_word(w, exp_w, {name, " panel word"});
		if (exp_addr.size() != 0) begin
			$display("%s left %0d expected stores unwritten", name, exp_addr.size());
			stop_on_failure();
		end
	endtask

	initial begin
		addr_t   base;
		opcode_t op;
		addr_t   a;
		int      p;
		int      k;
		int      len;
		rst_n = 1'b0;
		start = 1'b0;
		kl = '0;
		ignore_on = 1'b0;
		ignore_addr = '0;
		void'($urandom(32'hfd7dadfd));

		// arithmetic with wrap
		fill_memory();
		image[9'h100] = 16'hfff0;
		image[9'h101] = 16'h0020;
		image[9'h102] = 16'h0300;
		image[9'h103] = 16'h00f3;
		image[9'h010] = encode(op_lwt, 3'd1, 9'h1ff);
		image[9'h011] = encode(op_lw, 3'd2, 9'h100);
		image[9'h012] = encode(op_aw, 3'd2, 9'h101);
		image[9'h013] = encode(op_rw, 3'd2, 9'h180);
		image[9'h014] = encode(op_ac, 3'd1, 9'h102);
		image[9'h015] = encode(op_rw, 3'd1, 9'h181);
		image[9'h016] = encode(op_nr, 3'd2, 9'h103);
		image[9'h017] = encode(op_rw, 3'd2, 9'h182);
		image[9'h018] = encode(op_hlt, 3'd0, 9'h000);
		run_program(9'h010, "arithmetic program");

		// jumps, taken and not taken
		fill_memory();
		image[9'h110] = 16'h0005;
		image[9'h040] = encode(op_lwt, 3'd3, 9'h000);
		image[9'h041] = encode(op_jz, 3'd0, 9'h050);
		image[9'h042] = encode(op_rw, 3'd3, 9'h190);
		image[9'h043] = encode(op_hlt, 3'd0, 9'h000);
		image[9'h050] = encode(op_lwt, 3'd4, 9'h005);
		image[9'h051] = encode(op_jz, 3'd0, 9'h060);
		image[9'h052] = encode(op_rw, 3'd4, 9'h191);
		image[9'h053] = encode(op_ac, 3'd4, 9'h110);
		image[9'h054] = encode(op_jz, 3'd0, 9'h058);
		image[9'h055] = encode(op_hlt, 3'd0, 9'h000);
		image[9'h058] = encode(op_rw, 3'd4, 9'h192);
		image[9'h059] = encode(op_uj, 3'd0, 9'h070);
		image[9'h05a] = encode(op_rw, 3'd3, 9'h193);
		image[9'h070] = encode(op_lwt, 3'd5, 9'h0a5);
		image[9'h071] = encode(op_rw, 3'd5, 9'h194);
		image[9'h072] = 16'hb000;	// undefined code
		run_program(9'h040, "jump program");

		// straight-line random programs, code below 0x100 and data above
		for (p = 0; p < 20; p++) begin
			fill_memory();
			base = addr_t'($urandom_range(224, 0));
			len = $urandom_range(14, 3);
			for (k = 0; k < len; k++) begin
				op = opcode_t'(4'($urandom_range(6, 1)));	// op_lw through op_nr
				a = (op == op_lwt) ? addr_t'($urandom) : addr_t'(256 + $urandom_range(255, 0));
				image[base + addr_t'(k)] = encode(op, reg_idx_t'($urandom_range(7, 0)), a);
			end
			if ($urandom_range(1, 0) == 0) begin
				image[base + addr_t'(len)] = encode(op_hlt, 3'd0, 9'h000);
			end else begin
				image[base + addr_t'(len)] = {4'($urandom_range(15, 9)), 12'($urandom)};
			end
			run_program(base, $sformatf("random program %0d", p));
		end

		// store left unanswered
		fill_memory();
		image[9'h020] = encode(op_lwt, 3'd1, 9'h007);
		image[9'h021] = encode(op_rw, 3'd1, 9'h1a0);
		image[9'h022] = encode(op_hlt, 3'd0, 9'h000);
		exp_addr.delete();
		exp_data.delete();
		ignore_addr = 9'h1a0;
		ignore_on = 1'b1;
		launch(9'h020);
		expect_alarm(`MCPU_ALARM_DLY_TICKS + 200);
		hold_until_stopped(5);
		check_word(w, word_t'(9'h1a0), "panel word after alarm");
		for (k = 0; k < 20; k++) begin
			@(negedge __clk);
			check_run(run, 1'b0, "run after alarm");
			check_run(bus_req, 1'b0, "bus_req after alarm");
			check_run(alarm, 1'b1, "held alarm");
		end
		ignore_on = 1'b0;

		$display("All tests passed!");
		$finish;
	end

endmodule
